//--- project.f
laser_pkg.sv
laser_point_store.sv
laser_cover_count.sv
laser_search_ctrl.sv
laser_top.sv
tb_clk_gen.sv
tb_laser.sv

//--- Makefile
TOP = tb_laser

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- tb_laser.sv
`timescale 1ns/1ps

module tb_laser
    import laser_pkg::*;
();

    localparam int NUM_POINTS  = 40;
    localparam int NUM_PASSES  = 3;
    localparam int NUM_FRAMES  = 3;
    localparam int GRID_MAX    = (1 << COORD_W) - 1;
    localparam int SEND_LIMIT  = 20;
    localparam int DONE_LIMIT  = 60000;
    localparam int RESET_LIMIT = 50;

    logic               CLK;
    logic               RST;
    logic               pt_valid;
    logic [COORD_W-1:0] pt_x;
    logic [COORD_W-1:0] pt_y;
    logic               pt_credit;
    logic [COORD_W-1:0] c1_x, c1_y, c2_x, c2_y;
    logic               done;

    logic [31:0] lcg_state;
    int          pts_x [NUM_POINTS];
    int          pts_y [NUM_POINTS];
    bit          first_sent;
    logic        done_q = 1'b0;
    logic [15:0] held = '0;

    tb_clk_gen u_clk (
        .CLK (CLK),
        .RST (RST)
    );

    laser_top #(
        .NUM_POINTS (NUM_POINTS),
        .NUM_PASSES (NUM_PASSES)
    ) u_dut (
        .CLK       (CLK),
        .RST       (RST),
        .pt_valid  (pt_valid),
        .pt_x      (pt_x),
        .pt_y      (pt_y),
        .pt_credit (pt_credit),
        .c1_x      (c1_x),
        .c1_y      (c1_y),
        .c2_x      (c2_x),
        .c2_y      (c2_y),
        .done      (done)
    );

    task automatic fail_now(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "%s", msg);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // points inside the candidate circle, or inside either circle
    function automatic int count_cover(input int cx, input int cy, input int fx,
                                       input int fy, input bit with_fix);
        int n;
        int d1;
        int d2;
        n = 0;
        for (int i = 0; i < NUM_POINTS; i++) begin
            d1 = (pts_x[i] - cx) * (pts_x[i] - cx) + (pts_y[i] - cy) * (pts_y[i] - cy);
            d2 = (pts_x[i] - fx) * (pts_x[i] - fx) + (pts_y[i] - fy) * (pts_y[i] - fy);
            if (d1 <= RADIUS_SQ || (with_fix && d2 <= RADIUS_SQ)) begin
                n++;
            end
        end
        return n;
    endfunction

    // one circle's scan, row-major, later center wins a tie
    task automatic scan_best(input int ctr_x, input int ctr_y, input bit full,
                             input int fx, input int fy, input bit with_fix,
                             output int bx, output int by, output int bc);
        int lo_x, lo_y, hi_x, hi_y, c;
        lo_x = full ? 0 : ((ctr_x < WINDOW) ? 0 : ctr_x - WINDOW);
        lo_y = full ? 0 : ((ctr_y < WINDOW) ? 0 : ctr_y - WINDOW);
        hi_x = full ? GRID_MAX : ((ctr_x + WINDOW > GRID_MAX) ? GRID_MAX : ctr_x + WINDOW);
        hi_y = full ? GRID_MAX : ((ctr_y + WINDOW > GRID_MAX) ? GRID_MAX : ctr_y + WINDOW);
        bc = 0;
        bx = lo_x;
        by = lo_y;
        for (int y = lo_y; y <= hi_y; y++) begin
            for (int x = lo_x; x <= hi_x; x++) begin
                c = count_cover(x, y, fx, fy, with_fix);
                if (c >= bc) begin
                    bc = c;
                    bx = x;
                    by = y;
                end
            end
        end
    endtask

    task automatic run_model(output int e1x, output int e1y, output int e2x,
                             output int e2y, output int c1_only);
        int cnt;
        scan_best(0, 0, 1'b1, 0, 0, 1'b0, e1x, e1y, c1_only);
        scan_best(0, 0, 1'b1, e1x, e1y, 1'b1, e2x, e2y, cnt);
        for (int p = 1; p < NUM_PASSES; p++) begin
            scan_best(e1x, e1y, 1'b0, e2x, e2y, 1'b1, e1x, e1y, cnt);
            scan_best(e2x, e2y, 1'b0, e1x, e1y, 1'b1, e2x, e2y, cnt);
        end
    endtask

    // cluster puts every point near the (0,15) corner
    task automatic fill_frame(input bit cluster);
        logic [31:0] r;
        for (int i = 0; i < NUM_POINTS; i++) begin
            r = lcg_next();
            if (cluster) begin
                pts_x[i] = int'(r[31:24]) % 3;
                pts_y[i] = GRID_MAX - int'(r[23:16]) % 3;
            end else begin
                pts_x[i] = int'(r[31:28]);
                pts_y[i] = int'(r[27:24]);
            end
        end
    endtask

    task automatic run_frame(input bit cluster);
        int credits, returned, sent, idle, wait_cnt;
        int e1x, e1y, e2x, e2y, c1_only, got;
        fill_frame(cluster);
        run_model(e1x, e1y, e2x, e2y, c1_only);
        credits  = CREDIT_INIT;
        returned = 0;
        sent     = 0;
        idle     = 0;
        while (sent < NUM_POINTS) begin
            @(negedge CLK);
            pt_valid = 1'b0;
            assert (!done) else fail_now("done pulsed before the frame was complete");
            if (pt_credit) begin
                credits++;
                returned++;
            end
            if (credits > 0) begin
                pt_valid   = 1'b1;
                pt_x       = COORD_W'(pts_x[sent]);
                pt_y       = COORD_W'(pts_y[sent]);
                credits--;
                sent++;
                idle       = 0;
                first_sent = 1'b1;
            end else begin
                idle++;
                if (idle > SEND_LIMIT) begin
                    fail_now("timeout waiting for a credit from the DUT");
                end
            end
            assert (credits >= 0 && credits <= CREDIT_INIT)
                else fail_now($sformatf("sender credit count is %0d", credits));
        end
        wait_cnt = 0;
        @(negedge CLK);
        pt_valid = 1'b0;
        while (!done) begin
            assert (!pt_credit) else fail_now("pt_credit pulsed after the final point");
            wait_cnt++;
            if (wait_cnt > DONE_LIMIT) begin
                fail_now("timeout waiting for done after the final point");
            end
            @(negedge CLK);
        end
        assert (!pt_credit) else fail_now("pt_credit pulsed together with done");
        assert (returned == NUM_POINTS - CREDIT_INIT)
            else fail_now($sformatf("%0d credits returned in the frame", returned));
        got = count_cover(int'(c1_x), int'(c1_y), int'(c2_x), int'(c2_y), 1'b1);
        assert (got >= c1_only)
            else fail_now($sformatf("union count %0d below pass-0 count %0d", got, c1_only));
        assert (int'(c1_x) == e1x && int'(c1_y) == e1y)
            else fail_now($sformatf("c1 is (%0d,%0d), expected (%0d,%0d)",
                                    c1_x, c1_y, e1x, e1y));
        assert (int'(c2_x) == e2x && int'(c2_y) == e2y)
            else fail_now($sformatf("c2 is (%0d,%0d), expected (%0d,%0d)",
                                    c2_x, c2_y, e2x, e2y));
    endtask

    // reset quiet, done width and held outputs
    always @(negedge CLK) begin
        if (RST || !first_sent) begin
            assert (!pt_credit && !done)
                else fail_now("pt_credit or done high before the first point was sent");
        end
        assert (!(done && done_q)) else fail_now("done high for more than one cycle");
        done_q <= done;
        if (done) begin
            held <= {c1_x, c1_y, c2_x, c2_y};
        end else begin
            assert ({c1_x, c1_y, c2_x, c2_y} == held)
                else fail_now($sformatf("outputs changed to %h, held %h",
                                        {c1_x, c1_y, c2_x, c2_y}, held));
        end
    end

    initial begin
        int wait_cnt;
        pt_valid   = 1'b0;
        pt_x       = '0;
        pt_y       = '0;
        lcg_state  = 32'h589303c8;
        first_sent = 1'b0;
        wait_cnt   = 0;
        @(posedge CLK);
        while (RST) begin
            wait_cnt++;
            if (wait_cnt > RESET_LIMIT) begin
                fail_now("reset was never released");
            end
            @(posedge CLK);
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f == NUM_FRAMES - 1);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // eight full cycles, released on a falling edge
    initial begin
        RST = 1'b1;
        repeat (8) @(negedge CLK);
        RST = 1'b0;
    end

endmodule

//--- laser_top.sv
`timescale 1ns/1ps

module laser_top
    import laser_pkg::*;
#(
    parameter int NUM_POINTS = 40,
    parameter int NUM_PASSES = 3
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               pt_valid,
    input  logic [COORD_W-1:0] pt_x,
    input  logic [COORD_W-1:0] pt_y,
    output logic               pt_credit,
    output logic [COORD_W-1:0] c1_x,
    output logic [COORD_W-1:0] c1_y,
    output logic [COORD_W-1:0] c2_x,
    output logic [COORD_W-1:0] c2_y,
    output logic               done
);

    logic               clear;
    logic               frame_full;
    logic [5:0]         rd_idx;
    logic [COORD_W-1:0] rd_x, rd_y;
    logic               cnt_start;
    logic [COORD_W-1:0] cand_x, cand_y;
    logic [COORD_W-1:0] fix_x, fix_y;
    logic               use_fix;
    logic               cnt_valid;
    logic [5:0]         cnt_value;

    laser_point_store #(
        .NUM_POINTS (NUM_POINTS)
    ) u_store (
        .CLK        (CLK),
        .RST        (RST),
        .pt_valid   (pt_valid),
        .pt_x       (pt_x),
        .pt_y       (pt_y),
        .pt_credit  (pt_credit),
        .clear      (clear),
        .frame_full (frame_full),
        .rd_idx     (rd_idx),
        .rd_x       (rd_x),
        .rd_y       (rd_y)
    );

    laser_cover_count #(
        .NUM_POINTS (NUM_POINTS)
    ) u_count (
        .CLK       (CLK),
        .RST       (RST),
        .cnt_start (cnt_start),
        .cand_x    (cand_x),
        .cand_y    (cand_y),
        .fix_x     (fix_x),
        .fix_y     (fix_y),
        .use_fix   (use_fix),
        .rd_idx    (rd_idx),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .cnt_valid (cnt_valid),
        .cnt_value (cnt_value)
    );

    laser_search_ctrl #(
        .NUM_POINTS (NUM_POINTS),
        .NUM_PASSES (NUM_PASSES)
    ) u_ctrl (
        .CLK        (CLK),
        .RST        (RST),
        .frame_full (frame_full),
        .clear      (clear),
        .cnt_start  (cnt_start),
        .cand_x     (cand_x),
        .cand_y     (cand_y),
        .fix_x      (fix_x),
        .fix_y      (fix_y),
        .use_fix    (use_fix),
        .cnt_valid  (cnt_valid),
        .cnt_value  (cnt_value),
        .c1_x       (c1_x),
        .c1_y       (c1_y),
        .c2_x       (c2_x),
        .c2_y       (c2_y),
        .done       (done)
    );

endmodule

//--- laser_search_ctrl.sv
`timescale 1ns/1ps

module laser_search_ctrl
    import laser_pkg::*;
#(
    parameter int NUM_POINTS = 40,
    parameter int NUM_PASSES = 3
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               frame_full,
    output logic               clear,
    output logic               cnt_start,
    output logic [COORD_W-1:0] cand_x,
    output logic [COORD_W-1:0] cand_y,
    output logic [COORD_W-1:0] fix_x,
    output logic [COORD_W-1:0] fix_y,
    output logic               use_fix,
    input  logic               cnt_valid,
    input  logic [5:0]         cnt_value,
    output logic [COORD_W-1:0] c1_x,
    output logic [COORD_W-1:0] c1_y,
    output logic [COORD_W-1:0] c2_x,
    output logic [COORD_W-1:0] c2_y,
    output logic               done
);

    localparam int                 CNT_W     = $clog2(NUM_POINTS + 1);
    localparam int                 PASS_W    = $clog2(NUM_PASSES + 1);
    localparam logic [PASS_W-1:0]  LAST_PASS = PASS_W'(NUM_PASSES - 1);
    localparam logic [COORD_W-1:0] WIN       = COORD_W'(WINDOW);
    localparam logic [COORD_W-1:0] GRID_MAX  = '1;

    search_state_t      state;
    logic [PASS_W-1:0]  pass;
    logic [COORD_W-1:0] lo_x, hi_x, hi_y;
    logic [CNT_W-1:0]   best_cnt;
    logic [COORD_W-1:0] p1_x, p1_y, p2_x, p2_y;
    logic [COORD_W-1:0] ctr_x, ctr_y;
    logic [COORD_W-1:0] nxt_lo_x, nxt_lo_y, nxt_hi_x, nxt_hi_y;
    logic               full_scan;
    logic               start_scan;
    logic               scan_end;
    logic               better;

    function automatic logic [COORD_W-1:0] win_lo(input logic [COORD_W-1:0] c);
        return (c < WIN) ? '0 : c - WIN;
    endfunction

    function automatic logic [COORD_W-1:0] win_hi(input logic [COORD_W-1:0] c);
        return (c > GRID_MAX - WIN) ? GRID_MAX : c + WIN;
    endfunction

    assign clear   = (state == finish);
    assign use_fix = !((state == scan_c1) && (pass == '0));
    assign fix_x   = (state == scan_c2) ? p1_x : p2_x;
    assign fix_y   = (state == scan_c2) ? p1_y : p2_y;

    // ties go to the later candidate
    assign better   = (cnt_value >= 6'(best_cnt));
    assign scan_end = (cand_x == hi_x) && (cand_y == hi_y);

    always_comb begin
        // the circle about to be scanned: c2 after a c1 scan, otherwise c1
        if (state == scan_c1) begin
            ctr_x = p2_x;
            ctr_y = p2_y;
        end else begin
            ctr_x = p1_x;
            ctr_y = p1_y;
        end
        full_scan  = (state == load) || ((state == scan_c1) && (pass == '0));
        nxt_lo_x   = full_scan ? '0 : win_lo(ctr_x);
        nxt_lo_y   = full_scan ? '0 : win_lo(ctr_y);
        nxt_hi_x   = full_scan ? GRID_MAX : win_hi(ctr_x);
        nxt_hi_y   = full_scan ? GRID_MAX : win_hi(ctr_y);
        start_scan = ((state == load) && frame_full) ||
                     ((state == scan_c1) && cnt_valid && scan_end) ||
                     ((state == next_pass) && (pass != LAST_PASS));
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state     <= idle;
            pass      <= '0;
            cnt_start <= 1'b0;
            done      <= 1'b0;
            cand_x    <= '0;
            cand_y    <= '0;
            lo_x      <= '0;
            hi_x      <= '0;
            hi_y      <= '0;
            best_cnt  <= '0;
            p1_x      <= '0;
            p1_y      <= '0;
            p2_x      <= '0;
            p2_y      <= '0;
            c1_x      <= '0;
            c1_y      <= '0;
            c2_x      <= '0;
            c2_y      <= '0;
        end else begin
            cnt_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                idle: begin
                    state <= load;
                end
                load: begin
                    if (frame_full) begin
                        pass  <= '0;
                        state <= scan_c1;
                    end
                end
                scan_c1, scan_c2: begin
                    if (cnt_valid) begin
                        if (better) begin
                            best_cnt <= CNT_W'(cnt_value);
                            if (state == scan_c1) begin
                                p1_x <= cand_x;
                                p1_y <= cand_y;
                            end else begin
                                p2_x <= cand_x;
                                p2_y <= cand_y;
                            end
                        end
                        // row-major step inside the window
                        if (!scan_end) begin
                            cnt_start <= 1'b1;
                            if (cand_x == hi_x) begin
                                cand_x <= lo_x;
                                cand_y <= cand_y + COORD_W'(1);
                            end else begin
                                cand_x <= cand_x + COORD_W'(1);
                            end
                        end else if (state == scan_c1) begin
                            state <= scan_c2;
                        end else begin
                            state <= next_pass;
                        end
                    end
                end
                next_pass: begin
                    if (pass == LAST_PASS) begin
                        state <= finish;
                    end else begin
                        pass  <= pass + PASS_W'(1);
                        state <= scan_c1;
                    end
                end
                finish: begin
                    c1_x  <= p1_x;
                    c1_y  <= p1_y;
                    c2_x  <= p2_x;
                    c2_y  <= p2_y;
                    done  <= 1'b1;
                    state <= load;
                end
                default: begin
                    state <= idle;
                end
            endcase
            // new scan: window, first candidate, best count cleared
            if (start_scan) begin
                lo_x      <= nxt_lo_x;
                hi_x      <= nxt_hi_x;
                hi_y      <= nxt_hi_y;
                cand_x    <= nxt_lo_x;
                cand_y    <= nxt_lo_y;
                best_cnt  <= '0;
                cnt_start <= 1'b1;
            end
        end
    end

endmodule

//--- laser_cover_count.sv
`timescale 1ns/1ps

module laser_cover_count
    import laser_pkg::*;
#(
    parameter int NUM_POINTS = 40
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               cnt_start,
    input  logic [COORD_W-1:0] cand_x,
    input  logic [COORD_W-1:0] cand_y,
    input  logic [COORD_W-1:0] fix_x,
    input  logic [COORD_W-1:0] fix_y,
    input  logic               use_fix,
    output logic [5:0]         rd_idx,
    input  logic [COORD_W-1:0] rd_x,
    input  logic [COORD_W-1:0] rd_y,
    output logic               cnt_valid,
    output logic [5:0]         cnt_value
);

    localparam int               DIST_W   = 2 * COORD_W + 1;
    localparam logic [5:0]       LAST_IDX = 6'(NUM_POINTS - 1);
    localparam logic [DIST_W-1:0] R_SQ    = DIST_W'(RADIUS_SQ);

    logic               busy;
    logic [5:0]         idx;
    logic               s1_valid;
    logic               s1_last;
    logic [COORD_W-1:0] dx_c, dy_c;
    logic [COORD_W-1:0] dx_f, dy_f;
    logic [5:0]         count;
    logic               hit;

    function automatic logic [COORD_W-1:0] abs_diff(input logic [COORD_W-1:0] a,
                                                    input logic [COORD_W-1:0] b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic [DIST_W-1:0] dist_sq(input logic [COORD_W-1:0] dx,
                                                  input logic [COORD_W-1:0] dy);
        return DIST_W'(dx) * DIST_W'(dx) + DIST_W'(dy) * DIST_W'(dy);
    endfunction

    assign rd_idx    = idx;
    assign cnt_value = count;

    // partner circle only counts once c1 has been placed
    assign hit = (dist_sq(dx_c, dy_c) <= R_SQ) || (use_fix && (dist_sq(dx_f, dy_f) <= R_SQ));

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy      <= 1'b0;
            idx       <= '0;
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            cnt_valid <= 1'b0;
            count     <= '0;
        end else begin
            s1_valid  <= busy;
            s1_last   <= busy && (idx == LAST_IDX);
            cnt_valid <= s1_last;
            if (cnt_start) begin
                busy  <= 1'b1;
                idx   <= '0;
                count <= '0;
            end else if (busy) begin
                if (idx == LAST_IDX) begin
                    busy <= 1'b0;
                    idx  <= '0;
                end else begin
                    idx <= idx + 6'd1;
                end
            end
            // stage 2
            if (s1_valid) begin
                count <= count + 6'(hit);
            end
        end
    end

    // stage 1, distances to both centers
    always_ff @(posedge CLK) begin
        dx_c <= abs_diff(rd_x, cand_x);
        dy_c <= abs_diff(rd_y, cand_y);
        dx_f <= abs_diff(rd_x, fix_x);
        dy_f <= abs_diff(rd_y, fix_y);
    end

endmodule

//--- laser_point_store.sv
`timescale 1ns/1ps

module laser_point_store
    import laser_pkg::*;
#(
    parameter int NUM_POINTS = 40
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               pt_valid,
    input  logic [COORD_W-1:0] pt_x,
    input  logic [COORD_W-1:0] pt_y,
    output logic               pt_credit,
    input  logic               clear,
    output logic               frame_full,
    input  logic [5:0]         rd_idx,
    output logic [COORD_W-1:0] rd_x,
    output logic [COORD_W-1:0] rd_y
);

    localparam logic [5:0] LAST_IDX     = 6'(NUM_POINTS - 1);
    localparam logic [5:0] FULL_IDX     = 6'(NUM_POINTS);
    localparam logic [5:0] CREDIT_LIMIT = 6'(NUM_POINTS - CREDIT_INIT);

    logic [COORD_W-1:0] x_mem [NUM_POINTS];
    logic [COORD_W-1:0] y_mem [NUM_POINTS];
    logic [5:0]         wr_ptr;
    logic               accept;

    // pointer parks at NUM_POINTS until the controller clears it
    assign accept = pt_valid && (wr_ptr != FULL_IDX);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wr_ptr     <= '0;
            pt_credit  <= 1'b0;
            frame_full <= 1'b0;
        end else begin
            pt_credit  <= 1'b0;
            frame_full <= 1'b0;
            if (clear) begin
                wr_ptr <= '0;
            end else if (accept) begin
                wr_ptr     <= wr_ptr + 6'd1;
                // last CREDIT_INIT points get no credit back
                pt_credit  <= (wr_ptr < CREDIT_LIMIT);
                frame_full <= (wr_ptr == LAST_IDX);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            x_mem[wr_ptr] <= pt_x;
            y_mem[wr_ptr] <= pt_y;
        end
    end

    assign rd_x = x_mem[rd_idx];
    assign rd_y = y_mem[rd_idx];

endmodule

//--- laser_pkg.sv
package laser_pkg;

    // grid coordinate width, 16 by 16 grid
    parameter int COORD_W = 4;

    // a point is covered when dx*dx + dy*dy <= RADIUS_SQ
    parameter int RADIUS_SQ = 16;

    // refinement window half-width around the previous center
    parameter int WINDOW = 3;

    // credits the sender owns at the start of each frame
    parameter int CREDIT_INIT = 2;

    // search controller states
    typedef enum logic [2:0] {
        idle,
        load,
        scan_c1,
        scan_c2,
        next_pass,
        finish
    } search_state_t;

endpackage
